// ==== rtl/ecc_config.svh ====
`ifndef ECC_CONFIG_SVH
`define ECC_CONFIG_SVH

// Word geometry of the 93-bit Hsiao SEC-DED code

// Data bits carried in one protected word
`define ECC_DATA_WIDTH 93

// Check bits per word, seven Hamming bits plus the overall column parity bit
`define ECC_PARITY_WIDTH 8

// Width of the Hamming position held in the low syndrome bits
`define ECC_POS_WIDTH 7

`endif

// ==== rtl/ecc_pkg.sv ====
`default_nettype none

`include "ecc_config.svh"

package ecc_pkg;

    typedef struct packed {
        logic [`ECC_DATA_WIDTH-1:0]   data;
        logic [`ECC_PARITY_WIDTH-1:0] parity;
    } ecc_word_t;

    typedef struct packed {
        logic sbit_err; // Corrected or check-bit-only error
        logic dbit_err; // Uncorrectable
    } ecc_status_t;

    typedef struct packed {
        logic [`ECC_DATA_WIDTH-1:0]   data;
        logic [`ECC_PARITY_WIDTH-1:0] parity; // Check bits generated from the received data
        ecc_status_t                  status;
    } ecc_result_t;

    typedef enum logic [1:0] {
        SYN_ZERO = 2'd0,
        SYN_UNIT = 2'd1, // Exactly one check bit flipped
        SYN_ODD  = 2'd2,
        SYN_EVEN = 2'd3
    } syn_class_e;

    // Hamming position of data bit idx, skipping every power of two from 3 upward
    function automatic logic [`ECC_POS_WIDTH-1:0] hsiao_position(input int unsigned idx);
        int unsigned                seen;
        logic [`ECC_POS_WIDTH-1:0]  pos;
        seen = 0;
        pos  = '0;
        for (int unsigned p = 3; p < (1 << `ECC_POS_WIDTH); p++) begin
            if ((p & (p - 1)) != 0) begin
                if (seen == idx) begin
                    pos = `ECC_POS_WIDTH'(p);
                end
                seen++;
            end
        end
        return pos;
    endfunction

    // Top bit tops up an even-weight position so every data column has odd weight
    function automatic logic [`ECC_PARITY_WIDTH-1:0] hsiao_column(input int unsigned idx);
        logic [`ECC_POS_WIDTH-1:0] pos;
        pos = hsiao_position(idx);
        return {~^pos, pos};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/ecc_check_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module ecc_check_gen (
    input  wire  [`ECC_DATA_WIDTH-1:0]   data,
    input  wire  [`ECC_PARITY_WIDTH-1:0] parity_in,
    output logic [`ECC_PARITY_WIDTH-1:0] parity_gen,
    output logic [`ECC_PARITY_WIDTH-1:0] syndrome
);

    // One XOR tree per check bit over the data bits whose column has that row set
    for (genvar j = 0; j < `ECC_PARITY_WIDTH; j++) begin : g_row
        logic [`ECC_DATA_WIDTH-1:0] row_terms;

        for (genvar i = 0; i < `ECC_DATA_WIDTH; i++) begin : g_col
            localparam logic [`ECC_PARITY_WIDTH-1:0] COLUMN = ecc_pkg::hsiao_column(i);

            assign row_terms[i] = data[i] & COLUMN[j]; // Constant AND folds away in synthesis
        end

        assign parity_gen[j] = ^row_terms;
    end

    // A nonzero syndrome is the XOR of the columns of all flipped bits
    assign syndrome = parity_gen ^ parity_in;

endmodule

`default_nettype wire

// ==== rtl/ecc_syndrome_locator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module ecc_syndrome_locator (
    input  wire  [`ECC_PARITY_WIDTH-1:0] syndrome,
    output logic [`ECC_DATA_WIDTH-1:0]   mask,
    output logic                         hit
);

    localparam logic [`ECC_POS_WIDTH-1:0] LAST_POS =
        ecc_pkg::hsiao_position(`ECC_DATA_WIDTH - 1);

    logic [`ECC_POS_WIDTH-1:0] pos;
    logic                      pos_is_data;
    logic                      top_matches;

    // Full 8-bit compare against each data column
    for (genvar i = 0; i < `ECC_DATA_WIDTH; i++) begin : g_col
        localparam logic [`ECC_PARITY_WIDTH-1:0] COLUMN = ecc_pkg::hsiao_column(i);

        assign mask[i] = (syndrome == COLUMN);
    end

    // Hit is worked out from the position rule itself, not from the mask
    assign pos         = syndrome[`ECC_POS_WIDTH-1:0];
    assign pos_is_data = ((pos & (pos - 1'b1)) != '0) && (pos <= LAST_POS); // Not a check position
    assign top_matches = syndrome[`ECC_PARITY_WIDTH-1] == ~^pos;
    assign hit         = pos_is_data && top_matches;

    // Columns are distinct, so at most one can match
    ap_mask_onehot0: assert property (@(syndrome) $onehot0(mask))
        else $error("locator mask has more than one bit set: %h", mask);

    ap_hit_matches_mask: assert property (@(syndrome) hit == (mask != '0))
        else $error("locator hit %b disagrees with mask %h", hit, mask);

endmodule

`default_nettype wire

// ==== rtl/ecc_syndrome_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module ecc_syndrome_classifier (
    input  wire                  [`ECC_PARITY_WIDTH-1:0] syndrome,
    output ecc_pkg::syn_class_e                          syn_class
);

    logic [3:0] ones; // Holds 0 to 8

    always_comb begin
        ones = '0;
        for (int k = 0; k < `ECC_PARITY_WIDTH; k++) begin
            ones = ones + 4'(syndrome[k]);
        end
    end

    // Single data errors are odd, double errors are even
    always_comb begin
        if (ones == 4'd0) begin
            syn_class = ecc_pkg::SYN_ZERO;
        end else if (ones == 4'd1) begin
            syn_class = ecc_pkg::SYN_UNIT;
        end else if (ones[0]) begin
            syn_class = ecc_pkg::SYN_ODD;
        end else begin
            syn_class = ecc_pkg::SYN_EVEN;
        end
    end

    ap_zero_class: assert property (@(syndrome)
        (syn_class == ecc_pkg::SYN_ZERO) == (syndrome == '0))
        else $error("classifier zero class mismatch for syndrome %b", syndrome);

endmodule

`default_nettype wire

// ==== rtl/ecc_corrector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module ecc_corrector (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire                  [`ECC_DATA_WIDTH-1:0]   data,
    input  wire                  [`ECC_PARITY_WIDTH-1:0] parity_gen,
    input  wire                  [`ECC_DATA_WIDTH-1:0]   mask,
    input  wire                                          hit,
    input  wire ecc_pkg::syn_class_e                     syn_class,
    input  wire                                          bypass,
    output ecc_pkg::ecc_result_t                         result
);

    logic [`ECC_DATA_WIDTH-1:0] data_fix;
    ecc_pkg::ecc_status_t       status_nxt;
    ecc_pkg::ecc_result_t       result_nxt;

    always_comb begin
        data_fix   = data;
        status_nxt = '0;
        if (!bypass) begin
            case (syn_class)
                ecc_pkg::SYN_ZERO: begin
                    status_nxt = '0;
                end
                ecc_pkg::SYN_UNIT: begin
                    status_nxt.sbit_err = 1'b1; // Check bit was hit, data is already good
                end
                ecc_pkg::SYN_ODD: begin
                    if (hit) begin
                        data_fix            = data ^ mask;
                        status_nxt.sbit_err = 1'b1;
                    end else begin
                        status_nxt.dbit_err = 1'b1; // Odd but no column, three or more flips
                    end
                end
                default: begin
                    status_nxt.dbit_err = 1'b1;
                end
            endcase
        end
    end

    assign result_nxt.data   = data_fix;
    assign result_nxt.parity = parity_gen;
    assign result_nxt.status = status_nxt;

    // Output stage to break up the XOR tree and compare path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= result_nxt;
        end
    end

    ap_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(result.status.sbit_err && result.status.dbit_err))
        else $error("sbit_err and dbit_err both set");

    ap_bypass_silent: assert property (@(posedge clk) disable iff (!rst_n)
        bypass |=> (result.status == '0))
        else $error("error flag raised for a bypassed word");

endmodule

`default_nettype wire

// ==== rtl/ecc_93_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module ecc_93_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  ecc_pkg::ecc_word_t   word_in,
    input  wire                        bypass,
    output ecc_pkg::ecc_result_t       result
);

    logic [`ECC_PARITY_WIDTH-1:0] parity_gen;
    logic [`ECC_PARITY_WIDTH-1:0] syndrome;
    logic [`ECC_DATA_WIDTH-1:0]   mask;
    logic                         hit;
    ecc_pkg::syn_class_e          syn_class;

    ecc_check_gen u_check_gen (
        .data       (word_in.data),
        .parity_in  (word_in.parity),
        .parity_gen (parity_gen),
        .syndrome   (syndrome)
    );

    // Locator and classifier both work from the same syndrome in parallel
    ecc_syndrome_locator u_locator (
        .syndrome (syndrome),
        .mask     (mask),
        .hit      (hit)
    );

    ecc_syndrome_classifier u_classifier (
        .syndrome  (syndrome),
        .syn_class (syn_class)
    );

    ecc_corrector u_corrector (
        .clk        (clk),
        .rst_n      (rst_n),
        .data       (word_in.data),
        .parity_gen (parity_gen),
        .mask       (mask),
        .hit        (hit),
        .syn_class  (syn_class),
        .bypass     (bypass),
        .result     (result)
    );

endmodule

`default_nettype wire

// ==== verification/ecc_93_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module ecc_93_tb;

    localparam int  RESET_CYCLES = 10;
    localparam int  NUM_RANDOM   = 200;
    localparam int  NUM_SWEEP    = `ECC_DATA_WIDTH; // One flipped bit per data position
    localparam int  SLACK_CYCLES = 50;
    localparam byte COMMENT_CHAR = "#";

    typedef struct packed {
        ecc_pkg::ecc_word_t   word;
        logic                 bypass;
        ecc_pkg::ecc_result_t expected;
    } vector_t;

    logic                 clk;
    logic                 rst_n;
    ecc_pkg::ecc_word_t   word_in;
    logic                 bypass;
    ecc_pkg::ecc_result_t result;

    logic [`ECC_PARITY_WIDTH-1:0] column_table [`ECC_DATA_WIDTH];
    vector_t                      vectors [$];
    ecc_pkg::ecc_result_t         pending;
    logic                         pending_valid = 1'b0;
    logic                         limit_ready   = 1'b0;
    int                           error_count   = 0;
    int                           check_count   = 0;
    int                           cycle_count   = 0;
    int                           cycle_limit   = 0;

    ecc_93_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .word_in (word_in),
        .bypass  (bypass),
        .result  (result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Data bit i takes the i-th position from 3 upward that is not a power of two
    task automatic build_columns();
        int unsigned p;
        int          i;
        logic [6:0]  pos_bits;
        p = 3;
        i = 0;
        while (i < `ECC_DATA_WIDTH) begin
            pos_bits = p[6:0];
            if ($countones(p) != 1) begin
                column_table[i] = {($countones(pos_bits) % 2) == 0, pos_bits};
                i++;
            end
            p++;
        end
    endtask

    function automatic logic [`ECC_PARITY_WIDTH-1:0] parity_of(
        input logic [`ECC_DATA_WIDTH-1:0] data
    );
        logic [`ECC_PARITY_WIDTH-1:0] acc;
        acc = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (data[i]) begin
                acc = acc ^ column_table[i];
            end
        end
        return acc;
    endfunction

    task automatic load_vectors();
        int                           fd;
        int                           fields;
        string                        line;
        logic [`ECC_DATA_WIDTH-1:0]   data;
        logic [`ECC_PARITY_WIDTH-1:0] parity;
        logic                         byp;
        logic [`ECC_DATA_WIDTH-1:0]   exp_data;
        logic [`ECC_PARITY_WIDTH-1:0] exp_parity;
        logic                         exp_sbit;
        logic                         exp_dbit;
        vector_t                      vec;
        fd = $fopen("verification/ecc_93_testdata.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open verification/ecc_93_testdata.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != COMMENT_CHAR) begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h", data, parity, byp,
                                     exp_data, exp_parity, exp_sbit, exp_dbit);
                    if (fields == 7) begin
                        vec.word.data                = data;
                        vec.word.parity              = parity;
                        vec.bypass                   = byp;
                        vec.expected.data            = exp_data;
                        vec.expected.parity          = exp_parity;
                        vec.expected.status.sbit_err = exp_sbit;
                        vec.expected.status.dbit_err = exp_dbit;
                        vectors.push_back(vec);
                    end else if (fields > 0) begin
                        error_count++;
                        $display("Malformed line in the test data file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        if (vectors.size() == 0) begin
            error_count++;
            $display("No test vectors were read from the test data file");
        end
    endtask

    task automatic check_result(input ecc_pkg::ecc_result_t exp);
        check_count++;
        assert (result.data === exp.data) else begin
            error_count++;
            $display("ERROR %0t result.data: got %h expected %h", $time, result.data, exp.data);
        end
        assert (result.parity === exp.parity) else begin
            error_count++;
            $display("ERROR %0t result.parity: got %h expected %h",
                     $time, result.parity, exp.parity);
        end
        assert (result.status.sbit_err === exp.status.sbit_err) else begin
            error_count++;
            $display("ERROR %0t result.status.sbit_err: got %b expected %b",
                     $time, result.status.sbit_err, exp.status.sbit_err);
        end
        assert (result.status.dbit_err === exp.status.dbit_err) else begin
            error_count++;
            $display("ERROR %0t result.status.dbit_err: got %b expected %b",
                     $time, result.status.dbit_err, exp.status.dbit_err);
        end
    endtask

    // The word driven here shows up on result one rising edge later
    task automatic apply_word(
        input ecc_pkg::ecc_word_t   word,
        input logic                 byp,
        input ecc_pkg::ecc_result_t exp
    );
        @(negedge clk);
        if (pending_valid) begin
            check_result(pending);
        end
        word_in       = word;
        bypass        = byp;
        pending       = exp;
        pending_valid = 1'b1;
    endtask

    task automatic flush_pending();
        @(negedge clk);
        if (pending_valid) begin
            check_result(pending);
        end
        pending_valid = 1'b0;
    endtask

    initial begin : watchdog
        wait (limit_ready === 1'b1);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : stimulus
        ecc_pkg::ecc_word_t   word;
        ecc_pkg::ecc_result_t exp;
        logic [95:0]          raw;

        void'($urandom(32'hcaaf_09a8));
        rst_n          = 1'b0;
        word_in.data   = '1; // Nonzero input so a cleared output comes from reset alone
        word_in.parity = '0;
        bypass         = 1'b0;

        build_columns();
        load_vectors();
        cycle_limit = RESET_CYCLES + vectors.size() + NUM_RANDOM + NUM_SWEEP + SLACK_CYCLES;
        limit_ready = 1'b1;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_result('0);
        end
        rst_n   = 1'b1;
        word_in = '0;

        foreach (vectors[v]) begin
            apply_word(vectors[v].word, vectors[v].bypass, vectors[v].expected);
        end

        // Clean random words
        for (int n = 0; n < NUM_RANDOM; n++) begin
            raw         = {$urandom(), $urandom(), $urandom()};
            word.data   = raw[`ECC_DATA_WIDTH-1:0];
            word.parity = parity_of(word.data);
            exp.data    = word.data;
            exp.parity  = word.parity;
            exp.status  = '0;
            apply_word(word, 1'b0, exp);
        end

        // Every data position flipped once on a random clean word
        for (int b = 0; b < NUM_SWEEP; b++) begin
            raw                 = {$urandom(), $urandom(), $urandom()};
            exp.data            = raw[`ECC_DATA_WIDTH-1:0];
            word.parity         = parity_of(exp.data);
            word.data           = exp.data;
            word.data[b]        = ~word.data[b];
            exp.parity          = parity_of(word.data);
            exp.status.sbit_err = 1'b1;
            exp.status.dbit_err = 1'b0;
            apply_word(word, 1'b0, exp);
        end

        flush_pending();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/ecc_93_testdata.txt ====
# Columns: data, received check bits, bypass, expected data, expected generated check bits,
# expected sbit_err, expected dbit_err (all hex)
# Clean words
0 00 0 0 00 0 0
1 83 0 1 83 0 0
100000000000000000000000 64 0 100000000000000000000000 64 0 0
3 06 0 3 06 0 0
1FFFFFFFFFFFFFFFFFFFFFFF 9B 0 1FFFFFFFFFFFFFFFFFFFFFFF 9B 0 0
# One data bit flipped
1 00 0 0 83 1 0
8 00 0 0 07 1 0
800 00 0 0 91 1 0
2000000 00 0 0 1F 1 0
4000000 00 0 0 A1 1 0
100000000000000 00 0 0 BF 1 0
10000000000000000 00 0 0 C8 1 0
100000000000000000000000 00 0 0 64 1 0
1FFFFFFFFFFFFEFFFFFFFFFF 9B 0 1FFFFFFFFFFFFFFFFFFFFFFF B4 1 0
200000000000003 06 0 3 C7 1 0
# One check bit flipped
0 01 0 0 00 1 0
0 02 0 0 00 1 0
0 04 0 0 00 1 0
0 08 0 0 00 1 0
0 10 0 0 00 1 0
0 20 0 0 00 1 0
0 40 0 0 00 1 0
0 80 0 0 00 1 0
1 03 0 1 83 1 0
# Two bits flipped
3 00 0 3 06 0 1
FFFFFFFFFFFFFFFFFFFFFFE 9B 0 FFFFFFFFFFFFFFFFFFFFFFE 7C 0 1
10 01 0 10 89 0 1
0 03 0 0 00 0 1
0 24 0 0 00 0 1
C00 00 0 C00 1E 0 1
# Three bits flipped, odd syndrome above the last data position
0 70 0 0 00 0 1
100000000000000000000000 09 0 100000000000000000000000 64 0 1
100000000A00000000000000 00 0 100000000A00000000000000 E6 0 1
# Bypass passes corrupted words through with both flags low
1 00 1 1 83 0 0
3 00 1 3 06 0 0
0 80 1 0 00 0 0
100000000A00000000000000 00 1 100000000A00000000000000 E6 0 0
1FFFFFFFFFFFFEFFFFFFFFFF 9B 1 1FFFFFFFFFFFFEFFFFFFFFFF B4 0 0
1FFFFFFFFFFFFFFFFFFFFFFF 9B 1 1FFFFFFFFFFFFFFFFFFFFFFF 9B 0 0
# Back to correction right after bypass
1 00 0 0 83 1 0
0 00 0 0 00 0 0

// ==== list.f ====
+incdir+rtl
rtl/ecc_pkg.sv
rtl/ecc_check_gen.sv
rtl/ecc_syndrome_locator.sv
rtl/ecc_syndrome_classifier.sv
rtl/ecc_corrector.sv
rtl/ecc_93_top.sv
verification/ecc_93_tb.sv

// ==== Bender.yml ====
package:
  name: ecc_93

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ecc_pkg.sv
      - rtl/ecc_check_gen.sv
      - rtl/ecc_syndrome_locator.sv
      - rtl/ecc_syndrome_classifier.sv
      - rtl/ecc_corrector.sv
      - rtl/ecc_93_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/ecc_93_tb.sv
